/* common/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } j;
    } inst_t;

    typedef enum logic [5:0] {
        OP_NOP, // zero, so a cleared stage is a bubble
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLLI, OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU,
        OP_LUI, OP_AUIPC,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JAL, OP_JALR,
        OP_LW, OP_SW, OP_SB
    } op_e;

    typedef struct packed {
        op_e      op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
    } decoded_t;

    typedef struct packed {
        decoded_t dec;
        word_t    a;
        word_t    b;
        word_t    pc;
        logic     valid;
    } stage_t;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic       strobe;
        logic [9:0] idx;
        word_t      word;
    } prog_write_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } uart_tx_t;

endpackage

`default_nettype wire

/* decode/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import rv_pkg::*; (
    input  inst_t    i_inst,
    output decoded_t o_dec
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign imm_i = {{20{i_inst.i.imm[11]}}, i_inst.i.imm};
    assign imm_s = {{20{i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
    assign imm_b = {{19{i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                    i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
    assign imm_u = {i_inst.u.imm, 12'h000};
    assign imm_j = {{11{i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                    i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};

    always_comb begin
        o_dec.op  = OP_NOP;
        o_dec.rd  = i_inst.r.rd; // index fields sit at the same bits in every format
        o_dec.rs1 = i_inst.r.rs1;
        o_dec.rs2 = i_inst.r.rs2;
        o_dec.imm = '0;
        case (i_inst.r.opcode)
            OPC_OP: begin
                case ({i_inst.r.funct7, i_inst.r.funct3})
                    {7'h00, 3'b000}: o_dec.op = OP_ADD;
                    {7'h20, 3'b000}: o_dec.op = OP_SUB;
                    {7'h00, 3'b001}: o_dec.op = OP_SLL;
                    {7'h00, 3'b010}: o_dec.op = OP_SLT;
                    {7'h00, 3'b011}: o_dec.op = OP_SLTU;
                    {7'h00, 3'b100}: o_dec.op = OP_XOR;
                    {7'h00, 3'b101}: o_dec.op = OP_SRL;
                    {7'h20, 3'b101}: o_dec.op = OP_SRA;
                    {7'h00, 3'b110}: o_dec.op = OP_OR;
                    {7'h00, 3'b111}: o_dec.op = OP_AND;
                    default:         o_dec.op = OP_NOP;
                endcase
            end
            OPC_OP_IMM: begin
                o_dec.imm = imm_i;
                case (i_inst.i.funct3)
                    3'b000: o_dec.op = OP_ADDI;
                    3'b010: o_dec.op = OP_SLTI;
                    3'b011: o_dec.op = OP_SLTIU;
                    3'b100: o_dec.op = OP_XORI;
                    3'b110: o_dec.op = OP_ORI;
                    3'b111: o_dec.op = OP_ANDI;
                    3'b001: o_dec.op = (i_inst.r.funct7 == 7'h00) ? OP_SLLI : OP_NOP;
                    3'b101: begin
                        if (i_inst.r.funct7 == 7'h00) o_dec.op = OP_SRLI;
                        else if (i_inst.r.funct7 == 7'h20) o_dec.op = OP_SRAI;
                    end
                    default: o_dec.op = OP_NOP;
                endcase
            end
            OPC_LOAD: begin
                o_dec.imm = imm_i;
                if (i_inst.i.funct3 == 3'b010) o_dec.op = OP_LW;
            end
            OPC_STORE: begin
                o_dec.imm = imm_s;
                if (i_inst.s.funct3 == 3'b000) o_dec.op = OP_SB;
                else if (i_inst.s.funct3 == 3'b010) o_dec.op = OP_SW;
            end
            OPC_BRANCH: begin
                o_dec.imm = imm_b;
                case (i_inst.b.funct3)
                    3'b000:  o_dec.op = OP_BEQ;
                    3'b001:  o_dec.op = OP_BNE;
                    3'b100:  o_dec.op = OP_BLT;
                    3'b101:  o_dec.op = OP_BGE;
                    3'b110:  o_dec.op = OP_BLTU;
                    3'b111:  o_dec.op = OP_BGEU;
                    default: o_dec.op = OP_NOP;
                endcase
            end
            OPC_JAL: begin
                o_dec.imm = imm_j;
                o_dec.op  = OP_JAL;
            end
            OPC_JALR: begin
                o_dec.imm = imm_i;
                if (i_inst.i.funct3 == 3'b000) o_dec.op = OP_JALR;
            end
            OPC_LUI: begin
                o_dec.imm = imm_u;
                o_dec.op  = OP_LUI;
            end
            OPC_AUIPC: begin
                o_dec.imm = imm_u;
                o_dec.op  = OP_AUIPC;
            end
            default: o_dec.op = OP_NOP;
        endcase
    end

endmodule

`default_nettype wire

/* decode/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file import rv_pkg::*; (
    input  wire      clk,
    input  reg_idx_t i_rs1,
    input  reg_idx_t i_rs2,
    input  wb_t      i_wb,
    output word_t    o_a,
    output word_t    o_b
);

    word_t regs [1:31]; // x0 is not stored

    always_ff @(posedge clk) begin
        if (i_wb.we && i_wb.rd != 5'd0) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // x0 check first so a write to x0 is never bypassed
    always_comb begin
        if (i_rs1 == 5'd0) o_a = '0;
        else if (i_wb.we && i_wb.rd == i_rs1) o_a = i_wb.data;
        else o_a = regs[i_rs1];
    end

    always_comb begin
        if (i_rs2 == 5'd0) o_b = '0;
        else if (i_wb.we && i_wb.rd == i_rs2) o_b = i_wb.data;
        else o_b = regs[i_rs2];
    end

endmodule

`default_nettype wire

/* execute/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit import rv_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  stage_t      i_stage,
    input  word_t       i_load_data,
    output logic        o_redirect,
    output word_t       o_target,
    output wb_t         o_wb,
    output word_t       o_mem_addr,
    output logic [3:0]  o_wmask,
    output word_t       o_store_data
);

    stage_t ex;
    word_t  src_b;
    word_t  result;
    logic   taken;
    logic   writes_rd;

    // a taken branch squashes the instruction behind it
    always_ff @(posedge clk) begin
        if (reset || o_redirect) ex <= '0; // bubble
        else ex <= i_stage;
    end

    always_comb begin
        case (ex.dec.op)
            OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLLI, OP_SRLI, OP_SRAI,
            OP_SLTI, OP_SLTIU, OP_LW, OP_SW, OP_SB: src_b = ex.dec.imm;
            default:                                 src_b = ex.b;
        endcase
    end

    always_comb begin
        case (ex.dec.op)
            OP_ADD, OP_ADDI, OP_LW, OP_SW, OP_SB: result = ex.a + src_b; // also address
            OP_SUB:              result = ex.a - src_b;
            OP_AND, OP_ANDI:     result = ex.a & src_b;
            OP_OR, OP_ORI:       result = ex.a | src_b;
            OP_XOR, OP_XORI:     result = ex.a ^ src_b;
            OP_SLL, OP_SLLI:     result = ex.a << src_b[4:0];
            OP_SRL, OP_SRLI:     result = ex.a >> src_b[4:0];
            OP_SRA, OP_SRAI:     result = $signed(ex.a) >>> src_b[4:0];
            OP_SLT, OP_SLTI:     result = {31'd0, $signed(ex.a) < $signed(src_b)};
            OP_SLTU, OP_SLTIU:   result = {31'd0, ex.a < src_b};
            OP_LUI:              result = ex.dec.imm;
            OP_AUIPC:            result = ex.pc + ex.dec.imm;
            OP_JAL, OP_JALR:     result = ex.pc + 32'd4; // link
            default:             result = '0;
        endcase
    end

    always_comb begin
        case (ex.dec.op)
            OP_BEQ:          taken = ex.a == ex.b;
            OP_BNE:          taken = ex.a != ex.b;
            OP_BLT:          taken = $signed(ex.a) < $signed(ex.b);
            OP_BGE:          taken = $signed(ex.a) >= $signed(ex.b);
            OP_BLTU:         taken = ex.a < ex.b;
            OP_BGEU:         taken = ex.a >= ex.b;
            OP_JAL, OP_JALR: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign o_redirect = ex.valid && taken;
    assign o_target   = (ex.dec.op == OP_JALR) ? ((ex.a + ex.dec.imm) & ~32'd1)
                                               : ex.pc + ex.dec.imm;

    assign writes_rd = !(ex.dec.op inside {OP_NOP, OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
                                           OP_BLTU, OP_BGEU, OP_SW, OP_SB});

    assign o_wb.we   = ex.valid && writes_rd;
    assign o_wb.rd   = ex.dec.rd;
    assign o_wb.data = (ex.dec.op == OP_LW) ? i_load_data : result;

    assign o_mem_addr = result;

    always_comb begin
        o_wmask      = 4'b0000;
        o_store_data = ex.b;
        if (ex.valid && ex.dec.op == OP_SW) begin
            o_wmask = 4'b1111;
        end else if (ex.valid && ex.dec.op == OP_SB) begin
            o_wmask      = 4'b0001 << result[1:0];
            o_store_data = {4{ex.b[7:0]}}; // byte on every lane
        end
    end

endmodule

`default_nettype wire

/* execute/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory import rv_pkg::*; #(
    parameter int    DMEM_WORDS = 256,
    parameter word_t UART_ADDR  = 32'h20020
) (
    input  wire        clk,
    input  wire        reset,
    input  word_t      i_addr,
    input  wire  [3:0] i_wmask,
    input  word_t      i_wdata,
    output word_t      o_rdata,
    output uart_tx_t   o_uart
);

    localparam int DW = $clog2(DMEM_WORDS);

    word_t      mem [DMEM_WORDS];
    logic       uart_hit;
    logic       tx_valid;
    logic [7:0] tx_data;

    assign uart_hit = (i_wmask != 4'b0000) && (i_addr == UART_ADDR);

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (i_wmask[lane] && !uart_hit) begin
                mem[i_addr[DW+1:2]][8*lane +: 8] <= i_wdata[8*lane +: 8];
            end
        end
    end

    assign o_rdata = mem[i_addr[DW+1:2]];

    // transmit valid lasts one cycle
    always_ff @(posedge clk) begin
        if (reset) tx_valid <= 1'b0;
        else tx_valid <= uart_hit;
    end

    always_ff @(posedge clk) begin
        if (uart_hit) tx_data <= i_wdata[7:0];
    end

    assign o_uart.valid = tx_valid;
    assign o_uart.data  = tx_data;

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import rv_pkg::*; #(
    parameter int IMEM_WORDS = 256
) (
    input  wire         clk,
    input  wire         reset,
    input  prog_write_t i_prog,
    input  wire         i_redirect,
    input  word_t       i_target,
    output inst_t       o_inst,
    output word_t       o_pc,
    output logic        o_valid
);

    localparam int IW = $clog2(IMEM_WORDS);

    word_t imem [IMEM_WORDS];
    word_t pc;
    word_t next_pc;

    // program load port
    always_ff @(posedge clk) begin
        if (i_prog.strobe) begin
            imem[i_prog.idx[IW-1:0]] <= i_prog.word;
        end
    end

    always_comb begin
        if (i_redirect) next_pc = i_target; // redirect wins over hold
        else if (i_prog.strobe) next_pc = pc;
        else next_pc = pc + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (reset) pc <= '0;
        else pc <= next_pc;
    end

    assign o_inst  = imem[pc[IW+1:2]];
    assign o_pc    = pc;
    assign o_valid = !i_prog.strobe; // nothing issues while loading

endmodule

`default_nettype wire

/* source/riscv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_core import rv_pkg::*; #(
    parameter int    IMEM_WORDS = 256,
    parameter int    DMEM_WORDS = 256,
    parameter word_t UART_ADDR  = 32'h20020
) (
    input  wire         clk,
    input  wire         reset,
    input  prog_write_t i_prog,
    output uart_tx_t    o_uart
);

    inst_t    inst;
    word_t    pc;
    logic     inst_valid;
    decoded_t dec;
    word_t    rs1_data;
    word_t    rs2_data;
    stage_t   de_stage;
    logic     redirect;
    word_t    target;
    wb_t      wb;
    word_t    mem_addr;
    logic [3:0] wmask;
    word_t    store_data;
    word_t    load_data;

    fetch_unit #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .clk(clk), .reset(reset), .i_prog(i_prog),
        .i_redirect(redirect), .i_target(target),
        .o_inst(inst), .o_pc(pc), .o_valid(inst_valid)
    );

    instr_decoder u_decoder (.i_inst(inst), .o_dec(dec));

    register_file u_regs (
        .clk(clk), .i_rs1(dec.rs1), .i_rs2(dec.rs2), .i_wb(wb),
        .o_a(rs1_data), .o_b(rs2_data)
    );

    // decode side bundle for stage two
    assign de_stage.dec   = dec;
    assign de_stage.a     = rs1_data;
    assign de_stage.b     = rs2_data;
    assign de_stage.pc    = pc;
    assign de_stage.valid = inst_valid;

    execute_unit u_execute (
        .clk(clk), .reset(reset), .i_stage(de_stage), .i_load_data(load_data),
        .o_redirect(redirect), .o_target(target), .o_wb(wb),
        .o_mem_addr(mem_addr), .o_wmask(wmask), .o_store_data(store_data)
    );

    data_memory #(.DMEM_WORDS(DMEM_WORDS), .UART_ADDR(UART_ADDR)) u_dmem (
        .clk(clk), .reset(reset), .i_addr(mem_addr), .i_wmask(wmask),
        .i_wdata(store_data), .o_rdata(load_data), .o_uart(o_uart)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_reset = 1'b0; // released just after the edge, like other inputs
    end

endmodule

`default_nettype wire

/* testbench/tb_riscv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core import rv_pkg::*; ();

    localparam int CLK_PERIOD  = 10;
    localparam int DRIVE_DELAY = 1;
    localparam int TAIL_CYCLES = 50;
    localparam int MAX_WORDS   = 256;
    localparam int MAX_BYTES   = 256;

    wire         clk;
    wire         reset;
    prog_write_t prog;
    uart_tx_t    uart;

    logic [9:0]  prog_idx [MAX_WORDS];
    word_t       prog_word [MAX_WORDS];
    logic [7:0]  exp_bytes [MAX_BYTES];
    int          n_prog;
    int          n_exp;
    int          n_seen;
    logic        trace_done;
    logic        loading;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(4)) u_clock (
        .o_clk(clk), .o_reset(reset)
    );

    riscv_core #(.IMEM_WORDS(256), .DMEM_WORDS(256), .UART_ADDR(32'h20020)) u_dut (
        .clk(clk), .reset(reset), .i_prog(prog), .o_uart(uart)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_uart(input uart_tx_t got, input logic [7:0] exp, input int n);
        if (got.data !== exp) begin
            abort_run($sformatf("[FAIL] %0t ns: UART byte %0d is %02h, expected %02h",
                                $time, n, got.data, exp));
        end
    endtask

    task automatic read_trace();
        int          fd;
        int          code;
        string       line;
        logic [7:0]  tag;
        logic [31:0] f1;
        logic [31:0] f2;
        fd = $fopen("testbench/core_trace.txt", "r");
        if (fd == 0) abort_run("Could not open the trace file testbench/core_trace.txt");
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0) begin
                code = $sscanf(line, "%c %h %h", tag, f1, f2);
                if (tag == "P" && code == 3 && n_prog < MAX_WORDS) begin
                    prog_idx[n_prog]  = f1[9:0];
                    prog_word[n_prog] = f2;
                    n_prog++;
                end else if (tag == "E" && code >= 2 && n_exp < MAX_BYTES) begin
                    exp_bytes[n_exp] = f1[7:0];
                    n_exp++;
                end
            end
        end
        $fclose(fd);
        if (n_prog == 0 || n_exp == 0) begin
            abort_run("The trace file holds no program words or no expected bytes");
        end
    endtask

    // first word goes out as reset drops so the core never runs an empty memory
    task automatic load_program();
        wait (reset === 1'b0);
        for (int i = 0; i < n_prog; i++) begin
            if (i > 0) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            prog.strobe = 1'b1;
            prog.idx    = prog_idx[i];
            prog.word   = prog_word[i];
        end
        @(posedge clk);
        #DRIVE_DELAY;
        prog    = '0;
        loading = 1'b0;
    endtask

    // registered outputs sampled mid cycle
    always @(negedge clk) begin
        if (!reset && $isunknown(uart.valid)) begin
            abort_run("The UART valid output is unknown after reset");
        end
        if (uart.valid === 1'b1) begin
            if (loading) begin
                abort_run($sformatf("[FAIL] %0t ns: UART strobe during reset or program load",
                                    $time));
            end else if (n_seen >= n_exp) begin
                abort_run($sformatf("[FAIL] %0t ns: extra UART byte %02h after the last one",
                                    $time, uart.data));
            end else begin
                check_uart(uart, exp_bytes[n_seen], n_seen);
                n_seen++;
            end
        end
    end

    initial begin
        prog       = '0;
        loading    = 1'b1;
        n_prog     = 0;
        n_exp      = 0;
        n_seen     = 0;
        trace_done = 1'b0;
        read_trace();
        trace_done = 1'b1;
        load_program();
        while (n_seen < n_exp) @(posedge clk);
        repeat (TAIL_CYCLES) @(posedge clk); // nothing more may arrive
        $display("No errors");
        $finish;
    end

    // watchdog
    initial begin
        wait (trace_done);
        #((20 * n_prog + 100) * CLK_PERIOD);
        abort_run($sformatf("Timeout: only %0d of %0d UART bytes arrived within %0d cycles",
                            n_seen, n_exp, 20 * n_prog + 100));
    end

endmodule

`default_nettype wire

/* compile.f */
common/rv_pkg.sv
decode/instr_decoder.sv
decode/register_file.sv
execute/execute_unit.sv
execute/data_memory.sv
source/fetch_unit.sv
source/riscv_core.sv
testbench/tb_clock_gen.sv
testbench/tb_riscv_core.sv

/* testbench/core_trace.txt */
# P <word index> <instruction word>, E <expected UART byte>, all fields hex
# x1 holds the UART base 0x20000, every sb to 0x20(x1) sends one byte
P 00 000200b7  lui   x1, 0x20
P 01 f9c00113  addi  x2, x0, -100
P 02 00300193  addi  x3, x0, 3
P 03 0bd00a13  addi  x20, x0, 0xbd    bad byte, must never be sent
P 04 00310233  add   x4, x2, x3
P 05 02408023  sb    x4
P 06 402182b3  sub   x5, x3, x2
P 07 02508023  sb    x5
P 08 40315333  sra   x6, x2, x3
P 09 02608023  sb    x6
P 0a 01c15393  srli  x7, x2, 28
P 0b 02708023  sb    x7
P 0c 41c15413  srai  x8, x2, 28
P 0d 02808023  sb    x8
P 0e 003124b3  slt   x9, x2, x3
P 0f 02908023  sb    x9
P 10 00313533  sltu  x10, x2, x3
P 11 02a08023  sb    x10
P 12 f9d12593  slti  x11, x2, -99
P 13 02b08023  sb    x11
P 14 00514633  xor   x12, x2, x5
P 15 02c08023  sb    x12
P 16 0f017693  andi  x13, x2, 0xf0
P 17 02d08023  sb    x13
P 18 0401e713  ori   x14, x3, 0x40
P 19 02e08023  sb    x14
P 1a 003197b3  sll   x15, x3, x3
P 1b 02f08023  sb    x15
P 1c 00318463  beq   x3, x3, +8       taken
P 1d 03408023  sb    x20
P 1e 02508023  sb    x5
P 1f 00310463  beq   x2, x3, +8       not taken
P 20 02308023  sb    x3
P 21 00311463  bne   x2, x3, +8       taken
P 22 03408023  sb    x20
P 23 02508023  sb    x5
P 24 00319463  bne   x3, x3, +8       not taken
P 25 02308023  sb    x3
P 26 00314463  blt   x2, x3, +8       taken
P 27 03408023  sb    x20
P 28 02508023  sb    x5
P 29 0021c463  blt   x3, x2, +8       not taken
P 2a 02308023  sb    x3
P 2b 0021d463  bge   x3, x2, +8       taken
P 2c 03408023  sb    x20
P 2d 02508023  sb    x5
P 2e 00315463  bge   x2, x3, +8       not taken
P 2f 02308023  sb    x3
P 30 0021e463  bltu  x3, x2, +8       taken
P 31 03408023  sb    x20
P 32 02508023  sb    x5
P 33 00316463  bltu  x2, x3, +8       not taken
P 34 02308023  sb    x3
P 35 00317463  bgeu  x2, x3, +8       taken
P 36 03408023  sb    x20
P 37 02508023  sb    x5
P 38 0021f463  bgeu  x3, x2, +8       not taken
P 39 02308023  sb    x3
P 3a 00800aef  jal   x21, +8          link 0xec
P 3b 03408023  sb    x20
P 3c 03508023  sb    x21
P 3d 00000b17  auipc x22, 0           x22 = 0xf4
P 3e 00db0be7  jalr  x23, 13(x22)     target 0x100, link 0xfc
P 3f 03408023  sb    x20
P 40 03708023  sb    x23
P 41 03608023  sb    x22
P 42 10000c13  addi  x24, x0, 0x100
P 43 002c2023  sw    x2, 0(x24)
P 44 000c2c83  lw    x25, 0(x24)
P 45 001c8d13  addi  x26, x25, 1      uses the load right away
P 46 03a08023  sb    x26
P 47 05500013  addi  x0, x0, 0x55
P 48 02008023  sb    x0
P 49 0000006f  jal   x0, 0            park
E 9f  add
E 67  sub
E f3  sra
E 0f  srli
E ff  srai
E 01  slt
E 00  sltu
E 01  slti
E fb  xor
E 90  andi
E 43  ori
E 18  sll
E 67  beq taken
E 03  beq not taken
E 67  bne taken
E 03  bne not taken
E 67  blt taken
E 03  blt not taken
E 67  bge taken
E 03  bge not taken
E 67  bltu taken
E 03  bltu not taken
E 67  bgeu taken
E 03  bgeu not taken
E ec  jal link
E fc  jalr link
E f4  auipc
E 9d  lw then addi
E 00  x0 stays zero
